// File: source/ranging_consts.svh
`ifndef RANGING_CONSTS_SVH
`define RANGING_CONSTS_SVH

// width of echo times, accumulators and the report word.
`define RANGING_COUNT_W 24

// clock cycles per UART bit on the host link.
`define RANGING_CLKS_PER_BIT 16

// clock cycles between two ping strobes.
`define RANGING_PING_PERIOD 4096

// pings that make up one report window.
`define RANGING_PINGS_PER_WINDOW 8

// carrier periods per burst, each four clocks long.
`define RANGING_BURST_CYCLES 8

// fixed offset that every recorded echo time carries.
`define RANGING_ECHO_LATENCY 3

`endif

// File: source/ranging_pkg.sv
`include "ranging_consts.svh"

package ranging_pkg;

    // one echo time, accumulated sum or report word.
    typedef logic [`RANGING_COUNT_W-1:0] count_t;

    // pings issued so far in the current window, zero up to the window length.
    typedef logic [$clog2(`RANGING_PINGS_PER_WINDOW + 1)-1:0] ping_idx_t;

endpackage

// File: source/link_pkg.sv
package link_pkg;

    typedef logic [7:0] byte_t;

    // host command bytes, upper-case ASCII.
    typedef enum byte_t {
        CMD_START = 8'h53,
        CMD_STOP  = 8'h58
    } cmd_e;

endpackage

// File: source/uart_rx.sv
`include "ranging_consts.svh"

module uart_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx_serial,
    output link_pkg::byte_t rx_data,
    output logic            rx_stb,
    output logic            rx_err
);

    localparam int CLKS = `RANGING_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e       state;
    logic            rx_meta;
    logic            rx_sync;
    logic            rx_prev;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]      bit_idx;
    link_pkg::byte_t shift;

    // the line idles high, so the synchronizer resets to one.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_stb   <= 1'b0;
            rx_err   <= 1'b0;
        end else begin
            rx_stb <= 1'b0;
            rx_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // only a falling edge starts a byte, so a held-low line is ignored.
                    if (rx_prev && !rx_sync) begin
                        state    <= RX_START;
                        baud_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (baud_cnt == CNT_W'(CLKS / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == CNT_W'(CLKS - 1)) begin
                        baud_cnt <= '0;
                        shift    <= {rx_sync, shift[7:1]};
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (baud_cnt == CNT_W'(CLKS - 1)) begin
                        state <= RX_IDLE;
                        if (rx_sync) begin
                            rx_stb <= 1'b1;
                        end else begin
                            rx_err <= 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assign rx_data = shift;

endmodule

// File: source/uart_tx.sv
`include "ranging_consts.svh"

module uart_tx (
    input  logic            clk,
    input  logic            rst,
    input  logic            tx_valid,
    input  link_pkg::byte_t tx_data,
    output logic            tx_ready,
    output logic            tx_serial
);

    localparam int CLKS = `RANGING_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    logic             busy;
    logic [9:0]       frame;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;

    // the frame register shifts in ones, so the line rests high between bytes.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            frame    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (tx_valid) begin
                busy     <= 1'b1;
                frame    <= {1'b1, tx_data, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == CNT_W'(CLKS - 1)) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign tx_serial = frame[0];
    assign tx_ready  = !busy;

    // the producer must hold its byte until this transmitter takes it.
    tx_data_held: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> $stable(tx_data));

endmodule

// File: source/pulse_digitizer.sv
module pulse_digitizer (
    input  logic clk,
    input  logic rst,
    input  logic echo_in,
    output logic echo_stb
);

    logic echo_meta;
    logic echo_sync;
    logic echo_prev;

    // two flops take the comparator output into the clock domain.
    always_ff @(posedge clk) begin
        if (rst) begin
            echo_meta <= 1'b0;
            echo_sync <= 1'b0;
            echo_prev <= 1'b0;
            echo_stb  <= 1'b0;
        end else begin
            echo_meta <= echo_in;
            echo_sync <= echo_meta;
            echo_prev <= echo_sync;
            // one strobe per rising edge, however long the pulse lasts.
            echo_stb  <= echo_sync && !echo_prev;
        end
    end

endmodule

// File: source/burst_tx.sv
`include "ranging_consts.svh"

module burst_tx (
    input  logic clk,
    input  logic rst,
    input  logic ping_stb,
    output logic tx_out,
    output logic burst_active
);

    localparam int PERIOD_W = $clog2(`RANGING_BURST_CYCLES);

    logic [1:0]          phase;
    logic [PERIOD_W-1:0] period;

    always_ff @(posedge clk) begin
        if (rst) begin
            burst_active <= 1'b0;
            phase        <= '0;
            period       <= '0;
        end else if (ping_stb) begin
            burst_active <= 1'b1;
            phase        <= '0;
            period       <= '0;
        end else if (burst_active) begin
            phase <= phase + 1'b1;
            if (phase == 2'd3) begin
                period <= period + 1'b1;
                if (period == PERIOD_W'(`RANGING_BURST_CYCLES - 1)) begin
                    burst_active <= 1'b0;
                end
            end
        end
    end

    // phases 0 and 1 are the high half of each carrier period.
    assign tx_out = burst_active && !phase[1];

    // the ping period is longer than a burst, so a new ping never cuts one short.
    ping_after_burst: assert property (@(posedge clk) disable iff (rst)
        ping_stb |-> !burst_active);

endmodule

// File: source/ranging_ctrl.sv
`include "ranging_consts.svh"

module ranging_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  link_pkg::byte_t     rx_data,
    input  logic                rx_stb,
    input  logic                echo_stb,
    input  logic                burst_active,
    output logic                ping_stb,
    output logic                report_valid,
    output ranging_pkg::count_t report_value,
    input  logic                report_ready,
    output logic                running,
    output logic                echo_seen
);

    localparam int PERIOD_W = $clog2(`RANGING_PING_PERIOD);
    localparam int PINGS = `RANGING_PINGS_PER_WINDOW;
    // cycles from the tx_out rise to echo_stb that the timer already counts.
    localparam int ECHO_PATH_CYCLES = 3;

    logic [PERIOD_W-1:0]    period_cnt;
    ranging_pkg::ping_idx_t ping_idx;
    ranging_pkg::count_t    timer;
    ranging_pkg::count_t    first_t;
    ranging_pkg::count_t    last_t;
    ranging_pkg::count_t    acc_first;
    ranging_pkg::count_t    acc_last;
    ranging_pkg::count_t    report_sum;
    logic                   start_cmd;
    logic                   stop_cmd;
    logic                   period_end;
    logic                   window_end;
    logic                   echo_hit;

    assign start_cmd  = rx_stb && (rx_data == link_pkg::CMD_START);
    assign stop_cmd   = rx_stb && (rx_data == link_pkg::CMD_STOP);
    assign period_end = running && !stop_cmd && (period_cnt == PERIOD_W'(`RANGING_PING_PERIOD - 1));
    // the ping that opens a new window also closes the old one.
    assign window_end = ping_stb && running && !stop_cmd && !start_cmd
                        && (ping_idx == ranging_pkg::ping_idx_t'(PINGS));
    // edges during the burst are the transmitter itself.
    assign echo_hit   = running && echo_stb && !burst_active && !ping_stb;

    always_ff @(posedge clk) begin
        if (rst) begin
            running    <= 1'b0;
            ping_stb   <= 1'b0;
            period_cnt <= '0;
            ping_idx   <= '0;
        end else begin
            ping_stb <= start_cmd || period_end;
            if (stop_cmd) begin
                running <= 1'b0;
            end else if (start_cmd) begin
                running <= 1'b1;
            end
            if (start_cmd || period_end) begin
                period_cnt <= '0;
            end else if (running) begin
                period_cnt <= period_cnt + 1'b1;
            end
            if (start_cmd) begin
                ping_idx <= '0;
            end else if (ping_stb) begin
                ping_idx <= window_end ? ranging_pkg::ping_idx_t'(1) : ping_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            echo_seen <= 1'b0;
        end else if (start_cmd || ping_stb) begin
            echo_seen <= 1'b0;
        end else if (echo_hit) begin
            echo_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ping_stb) begin
            timer <= ranging_pkg::count_t'(`RANGING_ECHO_LATENCY - ECHO_PATH_CYCLES);
        end else begin
            timer <= timer + 1'b1;
        end
        if (echo_hit) begin
            if (!echo_seen) begin
                first_t <= timer;
            end
            last_t <= timer;
        end
    end

    always_ff @(posedge clk) begin
        if (start_cmd || window_end) begin
            acc_first <= '0;
            acc_last  <= '0;
        end else if (ping_stb && echo_seen) begin
            acc_first <= acc_first + first_t;
            acc_last  <= acc_last + last_t;
        end
    end

    // the last ping of the window is folded in here, as its strobe never comes.
    assign report_sum = acc_first + acc_last + (echo_seen ? first_t + last_t : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            report_valid <= 1'b0;
        end else if (window_end) begin
            report_valid <= 1'b1;
        end else if (report_valid && report_ready) begin
            report_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (window_end) begin
            report_value <= report_sum;
        end
    end

    ping_only_running: assert property (@(posedge clk) disable iff (rst)
        ping_stb |-> running);

    report_held: assert property (@(posedge clk) disable iff (rst)
        report_valid && !report_ready |=> $stable(report_value));

endmodule

// File: source/hex_report.sv
`include "ranging_consts.svh"

module hex_report (
    input  logic                clk,
    input  logic                rst,
    input  logic                report_valid,
    input  ranging_pkg::count_t report_value,
    output logic                report_ready,
    output logic                tx_valid,
    output link_pkg::byte_t     tx_data,
    input  logic                tx_ready
);

    localparam int NIBBLES = `RANGING_COUNT_W / 4;
    localparam int CHARS = NIBBLES + 2;
    localparam int IDX_W = $clog2(CHARS);

    logic                busy;
    logic [IDX_W-1:0]    char_idx;
    ranging_pkg::count_t value;
    logic [3:0]          nibble;

    assign nibble       = value[`RANGING_COUNT_W-1 -: 4];
    assign report_ready = !busy;
    assign tx_valid     = busy;

    // hex digits first, then CR and LF.
    always_comb begin
        if (char_idx == IDX_W'(NIBBLES)) begin
            tx_data = 8'h0D;
        end else if (char_idx == IDX_W'(NIBBLES + 1)) begin
            tx_data = 8'h0A;
        end else if (nibble < 4'd10) begin
            tx_data = 8'h30 + {4'h0, nibble};
        end else begin
            tx_data = 8'h37 + {4'h0, nibble};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            char_idx <= '0;
        end else if (!busy) begin
            if (report_valid) begin
                busy     <= 1'b1;
                char_idx <= '0;
            end
        end else if (tx_ready) begin
            char_idx <= char_idx + 1'b1;
            if (char_idx == IDX_W'(CHARS - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // the top nibble is always the one on the line.
    always_ff @(posedge clk) begin
        if (!busy && report_valid) begin
            value <= report_value;
        end else if (busy && tx_ready) begin
            value <= value << 4;
        end
    end

endmodule

// File: source/ranging_top.sv
module ranging_top (
    input  logic clk,
    input  logic rst,
    input  logic rx_serial,
    input  logic echo_in,
    output logic tx_serial,
    output logic tx_out,
    output logic running,
    output logic echo_seen
);

    link_pkg::byte_t     rx_data;
    logic                rx_stb;
    logic                echo_stb;
    logic                ping_stb;
    logic                burst_active;
    logic                report_valid;
    ranging_pkg::count_t report_value;
    logic                report_ready;
    logic                tx_valid;
    link_pkg::byte_t     tx_data;
    logic                tx_ready;

    // a byte with a bad stop bit is simply dropped.
    uart_rx uart_rx_i (
        .clk(clk), .rst(rst), .rx_serial(rx_serial),
        .rx_data(rx_data), .rx_stb(rx_stb), .rx_err()
    );

    pulse_digitizer pulse_digitizer_i (
        .clk(clk), .rst(rst), .echo_in(echo_in), .echo_stb(echo_stb)
    );

    burst_tx burst_tx_i (
        .clk(clk), .rst(rst), .ping_stb(ping_stb),
        .tx_out(tx_out), .burst_active(burst_active)
    );

    ranging_ctrl ranging_ctrl_i (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_stb(rx_stb),
        .echo_stb(echo_stb), .burst_active(burst_active), .ping_stb(ping_stb),
        .report_valid(report_valid), .report_value(report_value),
        .report_ready(report_ready), .running(running), .echo_seen(echo_seen)
    );

    hex_report hex_report_i (
        .clk(clk), .rst(rst), .report_valid(report_valid),
        .report_value(report_value), .report_ready(report_ready),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready)
    );

    uart_tx uart_tx_i (
        .clk(clk), .rst(rst), .tx_valid(tx_valid), .tx_data(tx_data),
        .tx_ready(tx_ready), .tx_serial(tx_serial)
    );

endmodule

// File: tests/tb_ranging.sv
`include "ranging_consts.svh"

module tb_ranging;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS = `RANGING_CLKS_PER_BIT;
    localparam int PING_PERIOD = `RANGING_PING_PERIOD;
    localparam int PINGS = `RANGING_PINGS_PER_WINDOW;
    localparam int LAT = `RANGING_ECHO_LATENCY;
    localparam int BURST_CLKS = `RANGING_BURST_CYCLES * 4;

    logic        clk;
    logic        rst;
    logic        rx_serial;
    logic        echo_in;
    logic        tx_serial;
    logic        tx_out;
    logic        running;
    logic        echo_seen;
    logic [31:0] rng_state;

    ranging_top ranging_top_i (
        .clk(clk), .rst(rst), .rx_serial(rx_serial), .echo_in(echo_in),
        .tx_serial(tx_serial), .tx_out(tx_out), .running(running), .echo_seen(echo_seen)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int pick_offset(input int lo, input int span);
        rng_state = xorshift32(rng_state);
        return lo + int'(rng_state % 32'(span));
    endfunction

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic check_byte(input string name, input link_pkg::byte_t got,
                              input link_pkg::byte_t expected);
        if (got !== expected) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    // the first received character sits in the top byte of chars.
    task automatic check_count(input string name, input logic [47:0] chars,
                               input ranging_pkg::count_t expected);
        ranging_pkg::count_t got;
        link_pkg::byte_t     c;
        got = '0;
        for (int i = 5; i >= 0; i--) begin
            c = chars[i*8 +: 8];
            if (c >= 8'h30 && c <= 8'h39) begin
                got = (got << 4) | ranging_pkg::count_t'(c - 8'h30);
            end else if (c >= 8'h41 && c <= 8'h46) begin
                got = (got << 4) | ranging_pkg::count_t'(c - 8'h37);
            end else begin
                abort_run($sformatf("report character 0x%h is not a hex digit", c));
            end
        end
        if (got !== expected) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic send_byte(input link_pkg::byte_t data, input logic bad_stop);
        rx_serial = 1'b0;
        repeat (CLKS) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx_serial = data[i];
            repeat (CLKS) @(negedge clk);
        end
        rx_serial = !bad_stop;
        repeat (CLKS) @(negedge clk);
        rx_serial = 1'b1;
        repeat (CLKS) @(negedge clk);
    endtask

    task automatic recv_byte(output link_pkg::byte_t data);
        int guard;
        guard = 0;
        while (tx_serial !== 1'b0) begin
            @(negedge clk);
            guard++;
            if (guard > 2 * PING_PERIOD) begin
                abort_run("no byte arrived on tx_serial in time");
            end
        end
        repeat (CLKS / 2) @(negedge clk);
        if (tx_serial !== 1'b0) begin
            abort_run("start bit on tx_serial was too short");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clk);
            data[i] = tx_serial;
        end
        repeat (CLKS) @(negedge clk);
        if (tx_serial !== 1'b1) begin
            abort_run("stop bit on tx_serial was low");
        end
    endtask

    // offsets count clocks from the first high sample of the burst.
    // A negative offset skips that pulse.
    task automatic echo_after(input int k_a, input int k_b, input int k_c);
        int   offs[3];
        int   t;
        int   guard;
        logic prev;
        offs = '{k_a, k_b, k_c};
        prev = 1'b1;
        guard = 0;
        while (!(prev === 1'b0 && tx_out === 1'b1)) begin
            prev = tx_out;
            @(negedge clk);
            guard++;
            if (guard > 2 * PING_PERIOD) begin
                abort_run("no burst appeared on tx_out in time");
            end
        end
        t = 0;
        for (int i = 0; i < 3; i++) begin
            if (offs[i] >= 0) begin
                while (t < offs[i]) begin
                    @(negedge clk);
                    t++;
                end
                echo_in = 1'b1;
                repeat (4) @(negedge clk);
                t += 4;
                echo_in = 1'b0;
            end
        end
        // step past the carrier so its later edges are not taken for a new burst.
        while (t < BURST_CLKS + 16) begin
            @(negedge clk);
            t++;
        end
    endtask

    task automatic read_report(input ranging_pkg::count_t expected);
        logic [47:0]     chars;
        link_pkg::byte_t b;
        chars = '0;
        for (int i = 0; i < 6; i++) begin
            recv_byte(b);
            chars = {chars[39:0], b};
        end
        check_count("report", chars, expected);
        recv_byte(b);
        check_byte("report_cr", b, 8'h0D);
        recv_byte(b);
        check_byte("report_lf", b, 8'h0A);
    endtask

    task automatic quiet_for(input int cycles, input logic run_level);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_bit("tx_serial", tx_serial, 1'b1);
            check_bit("tx_out", tx_out, 1'b0);
            check_bit("running", running, run_level);
        end
    endtask

    task automatic idle_after_reset();
        quiet_for(2 * PING_PERIOD, 1'b0);
    endtask

    task automatic fixed_echo_window();
        int k;
        k = 100;
        fork
            send_byte(link_pkg::CMD_START, 1'b0);
            for (int i = 0; i < PINGS; i++) begin
                echo_after(k, -1, -1);
            end
        join
        read_report(ranging_pkg::count_t'(2 * PINGS * (k + LAT)));
        check_bit("running", running, 1'b1);
    endtask

    task automatic random_echo_window();
        ranging_pkg::count_t expected;
        int                  k1;
        int                  k2;
        expected = '0;
        fork
            send_byte(link_pkg::CMD_START, 1'b0);
            for (int i = 0; i < PINGS; i++) begin
                if (i % 4 == 3) begin
                    echo_after(-1, -1, -1);
                    check_bit("echo_seen", echo_seen, 1'b0);
                end else begin
                    k1 = pick_offset(BURST_CLKS + 8, 1800);
                    k2 = k1 + pick_offset(8, 1800);
                    echo_after(k1, k2, -1);
                    check_bit("echo_seen", echo_seen, 1'b1);
                    expected = expected + ranging_pkg::count_t'(k1 + LAT + k2 + LAT);
                end
            end
        join
        read_report(expected);
    endtask

    task automatic blanked_burst_echo();
        ranging_pkg::count_t expected;
        int                  k1;
        expected = '0;
        fork
            send_byte(link_pkg::CMD_START, 1'b0);
            for (int i = 0; i < PINGS; i++) begin
                k1 = pick_offset(BURST_CLKS + 8, 3000);
                echo_after(6, k1, -1);
                expected = expected + ranging_pkg::count_t'(2 * (k1 + LAT));
            end
        join
        read_report(expected);
    endtask

    task automatic command_handling();
        send_byte(link_pkg::CMD_STOP, 1'b0);
        check_bit("running", running, 1'b0);
        send_byte(link_pkg::CMD_START, 1'b1);
        send_byte(8'h41, 1'b0);
        quiet_for(2 * PINGS * PING_PERIOD, 1'b0);
        // these three pings are thrown away by the restart below.
        fork
            send_byte(link_pkg::CMD_START, 1'b0);
            for (int i = 0; i < 3; i++) begin
                echo_after(500, -1, -1);
            end
        join
        fork
            send_byte(link_pkg::CMD_START, 1'b0);
            for (int i = 0; i < PINGS; i++) begin
                echo_after(77, -1, -1);
            end
        join
        read_report(ranging_pkg::count_t'(2 * PINGS * (77 + LAT)));
        check_bit("running", running, 1'b1);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rx_serial = 1'b1;
        echo_in = 1'b0;
        rng_state = 32'd71;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        idle_after_reset();
        fixed_echo_window();
        random_echo_window();
        blanked_burst_echo();
        command_handling();
        $display("Test OK");
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
source/ranging_pkg.sv
source/link_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/pulse_digitizer.sv
source/burst_tx.sv
source/ranging_ctrl.sv
source/hex_report.sv
source/ranging_top.sv
tests/tb_ranging.sv

// File: Bender.yml
package:
  name: ranging

sources:
  - include_dirs:
      - source
    files:
      - source/ranging_pkg.sv
      - source/link_pkg.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/pulse_digitizer.sv
      - source/burst_tx.sv
      - source/ranging_ctrl.sv
      - source/hex_report.sv
      - source/ranging_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_ranging.sv
